/* Bender.yml */
package:
  name: ara_mini

sources:
  - rtl/ara_pkg.sv
  - rtl/spill_register.sv
  - rtl/ara_dispatcher.sv
  - rtl/ara_sequencer.sv
  - rtl/vector_lane.sv
  - rtl/mask_unit.sv
  - rtl/ara_top.sv
  - target: simulation
    files:
      - verification/ara_properties.sv
      - verification/ara_tb.sv

/* rtl/ara_dispatcher.sv */
//////////////////////////////////////////////////////////////////////
// Dispatcher
// Buffers host requests, rejects illegal op codes and forms responses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ara_dispatcher (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  ara_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  output ara_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  output ara_pkg::ara_req_t  ara_req_o,
  output logic               ara_req_valid_o,
  input  logic               ara_req_ready_i,
  input  ara_pkg::elen_t     ara_resp_result_i,
  input  logic               ara_resp_valid_i
);

  import ara_pkg::*;

  acc_req_t  req;
  logic      req_valid;
  logic      req_ready;
  logic      req_in_ready;
  logic      legal;
  acc_resp_t resp_in;
  logic      resp_in_valid;
  logic      resp_in_ready;
  logic      busy_q;

  // One instruction at a time, from acceptance until the response is taken
  assign acc_req_ready_o = req_in_ready & ~busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (acc_req_valid_i && acc_req_ready_o) begin
      busy_q <= 1'b1;
    end else if (acc_resp_valid_o && acc_resp_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  spill_register #(
    .payload_t(acc_req_t)
  ) i_req_spill (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(acc_req_valid_i & ~busy_q),
    .ready_o(req_in_ready),
    .data_i (acc_req_i),
    .valid_o(req_valid),
    .ready_i(req_ready),
    .data_o (req)
  );

  ///////////////////////////////////////////////////////////////////
  // Decode
  ///////////////////////////////////////////////////////////////////

  assign legal = req.op inside {OP_VMV_VX, OP_VID, OP_VADD, OP_VSUB,
                                OP_VAND, OP_VXOR, OP_VMV_XS, OP_VCPOP};

  assign ara_req_o = '{
    op:     ara_op_e'(req.op),
    vd:     req.vd,
    vs1:    req.vs1,
    vs2:    req.vs2,
    scalar: req.scalar
  };
  assign ara_req_valid_o = req_valid & legal;

  // Illegal ops skip the sequencer and go straight to the response buffer
  assign req_ready = legal ? ara_req_ready_i : resp_in_ready;

  ///////////////////////////////////////////////////////////////////
  // Response
  ///////////////////////////////////////////////////////////////////

  assign resp_in_valid = (req_valid & ~legal) | ara_resp_valid_i;
  assign resp_in = ara_resp_valid_i ? '{result: ara_resp_result_i, error: 1'b0}
                                    : '{result: '0, error: 1'b1};

  spill_register #(
    .payload_t(acc_resp_t)
  ) i_resp_spill (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(resp_in_valid),
    .ready_o(resp_in_ready),
    .data_i (resp_in),
    .valid_o(acc_resp_valid_o),
    .ready_i(acc_resp_ready_i),
    .data_o (acc_resp_o)
  );

endmodule : ara_dispatcher

`default_nettype wire

/* rtl/ara_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Vector accelerator package
// Machine sizes, operation codes and the request and response records
// shared by dispatcher, sequencer, lanes and mask unit
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ara_pkg;

  // Machine geometry
  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 2;
  localparam int unsigned VLenElems    = NrLanes * ElemsPerLane;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned ELEN         = 16;

  typedef logic [ELEN-1:0]                 elen_t;
  typedef logic [$clog2(NrVRegs)-1:0]      vreg_idx_t;
  typedef logic [$clog2(ElemsPerLane)-1:0] slot_idx_t;
  // Holds 0 up to VLenElems
  typedef logic [$clog2(VLenElems+1)-1:0]  cpop_t;

  // Supported operations, remaining codes are illegal
  typedef enum logic [3:0] {
    OP_VMV_VX = 4'd0,
    OP_VID    = 4'd1,
    OP_VADD   = 4'd2,
    OP_VSUB   = 4'd3,
    OP_VAND   = 4'd4,
    OP_VXOR   = 4'd5,
    OP_VMV_XS = 4'd6,
    OP_VCPOP  = 4'd7
  } ara_op_e;

  // Host request, op is still the raw code
  typedef struct packed {
    logic [3:0] op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    elen_t      scalar;
  } acc_req_t;

  typedef struct packed {
    elen_t result;
    logic  error;
  } acc_resp_t;

  // Decoded instruction for sequencer and processing elements
  typedef struct packed {
    ara_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elen_t     scalar;
  } ara_req_t;

endpackage : ara_pkg

`default_nettype wire

/* rtl/ara_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// Sequencer
// Broadcasts each instruction to the processing elements, tracks their
// completion and returns the scalar result
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ara_sequencer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  ara_pkg::ara_req_t           ara_req_i,
  input  logic                        ara_req_valid_i,
  output logic                        ara_req_ready_o,
  output ara_pkg::elen_t              ara_resp_result_o,
  output logic                        ara_resp_valid_o,
  output ara_pkg::ara_req_t           pe_req_o,
  output logic                        pe_req_valid_o,
  input  logic [ara_pkg::NrLanes-1:0] lane_ready_i,
  input  logic                        masku_ready_i,
  input  logic [ara_pkg::NrLanes-1:0] lane_done_i,
  input  logic                        masku_done_i,
  input  ara_pkg::elen_t              scalar_elem_i,
  input  ara_pkg::cpop_t              cpop_result_i
);

  import ara_pkg::*;

  logic               busy_q;
  logic [NrLanes-1:0] lane_pend_q;
  logic               masku_pend_q;
  logic               all_clear;
  logic               issue;
  logic               resp_valid_q;
  ara_op_e            op_q;
  elen_t              result_d;
  elen_t              result_q;

  // Issue only into idle processing elements
  assign ara_req_ready_o = ~busy_q & (&lane_ready_i) & masku_ready_i;
  assign issue           = ara_req_valid_i & ara_req_ready_o;

  assign pe_req_o       = ara_req_i;
  assign pe_req_valid_o = issue;

  // Lanes usually finish together, still wait for each one
  assign all_clear = ~(|lane_pend_q) & ~masku_pend_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      lane_pend_q  <= '0;
      masku_pend_q <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= 1'b0;
      if (issue) begin
        busy_q       <= 1'b1;
        lane_pend_q  <= '1;
        masku_pend_q <= 1'b1;
      end else begin
        lane_pend_q  <= lane_pend_q & ~lane_done_i;
        masku_pend_q <= masku_pend_q & ~masku_done_i;
        if (busy_q && all_clear) begin
          busy_q       <= 1'b0;
          resp_valid_q <= 1'b1;
        end
      end
    end
  end

  // Result source by operation
  always_comb begin
    case (op_q)
      OP_VMV_XS: result_d = scalar_elem_i;
      OP_VCPOP:  result_d = elen_t'(cpop_result_i);
      default:   result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      op_q <= ara_req_i.op;
    end
    if (busy_q && all_clear) begin
      result_q <= result_d;
    end
  end

  assign ara_resp_valid_o  = resp_valid_q;
  assign ara_resp_result_o = result_q;

endmodule : ara_sequencer

`default_nettype wire

/* rtl/ara_top.sv */
//////////////////////////////////////////////////////////////////////
// Vector accelerator top level
// Dispatcher, sequencer, lanes and mask unit behind one host port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ara_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  ara_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  output ara_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);

  import ara_pkg::*;

  ara_req_t            ara_req;
  logic                ara_req_valid;
  logic                ara_req_ready;
  elen_t               ara_resp_result;
  logic                ara_resp_valid;
  ara_req_t            pe_req;
  logic                pe_req_valid;
  logic  [NrLanes-1:0] lane_ready;
  logic  [NrLanes-1:0] lane_done;
  logic  [NrLanes-1:0] mask_bit;
  logic  [NrLanes-1:0] mask_bit_valid;
  // Only lane 0 holds element 0
  elen_t [NrLanes-1:0] lane_scalar;
  logic                masku_ready;
  logic                masku_done;
  cpop_t               cpop_result;

  ara_dispatcher i_dispatcher (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .acc_req_i        (acc_req_i),
    .acc_req_valid_i  (acc_req_valid_i),
    .acc_req_ready_o  (acc_req_ready_o),
    .acc_resp_o       (acc_resp_o),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .ara_req_o        (ara_req),
    .ara_req_valid_o  (ara_req_valid),
    .ara_req_ready_i  (ara_req_ready),
    .ara_resp_result_i(ara_resp_result),
    .ara_resp_valid_i (ara_resp_valid)
  );

  ara_sequencer i_sequencer (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ara_req_i        (ara_req),
    .ara_req_valid_i  (ara_req_valid),
    .ara_req_ready_o  (ara_req_ready),
    .ara_resp_result_o(ara_resp_result),
    .ara_resp_valid_o (ara_resp_valid),
    .pe_req_o         (pe_req),
    .pe_req_valid_o   (pe_req_valid),
    .lane_ready_i     (lane_ready),
    .masku_ready_i    (masku_ready),
    .lane_done_i      (lane_done),
    .masku_done_i     (masku_done),
    .scalar_elem_i    (lane_scalar[0]),
    .cpop_result_i    (cpop_result)
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vector_lane #(
      .LaneId(l)
    ) i_lane (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .pe_req_i        (pe_req),
      .pe_req_valid_i  (pe_req_valid),
      .pe_req_ready_o  (lane_ready[l]),
      .done_o          (lane_done[l]),
      .mask_bit_o      (mask_bit[l]),
      .mask_bit_valid_o(mask_bit_valid[l]),
      .scalar_elem_o   (lane_scalar[l])
    );
  end : gen_lanes

  mask_unit i_masku (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .pe_req_i        (pe_req),
    .pe_req_valid_i  (pe_req_valid),
    .pe_req_ready_o  (masku_ready),
    .mask_bit_i      (mask_bit),
    .mask_bit_valid_i(mask_bit_valid),
    .cpop_result_o   (cpop_result),
    .done_o          (masku_done)
  );

endmodule : ara_top

`default_nettype wire

/* rtl/mask_unit.sv */
//////////////////////////////////////////////////////////////////////
// Mask unit
// Counts the set bit-0 mask bits that the lanes stream in
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mask_unit (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  ara_pkg::ara_req_t           pe_req_i,
  input  logic                        pe_req_valid_i,
  output logic                        pe_req_ready_o,
  input  logic [ara_pkg::NrLanes-1:0] mask_bit_i,
  input  logic [ara_pkg::NrLanes-1:0] mask_bit_valid_i,
  output ara_pkg::cpop_t              cpop_result_o,
  output logic                        done_o
);

  import ara_pkg::*;

  logic      busy_q;
  logic      done_q;
  logic      accept;
  slot_idx_t beat_q;
  cpop_t     cnt_q;
  cpop_t     beat_pop;

  assign pe_req_ready_o = ~busy_q;
  assign accept         = pe_req_valid_i & pe_req_ready_o;

  // Set bits across lanes in this cycle
  always_comb begin
    beat_pop = '0;
    for (int l = 0; l < NrLanes; l++) begin
      beat_pop = beat_pop + cpop_t'(mask_bit_i[l] & mask_bit_valid_i[l]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      beat_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        beat_q <= '0;
        // Nothing to count for other ops
        if (pe_req_i.op == OP_VCPOP) begin
          busy_q <= 1'b1;
        end else begin
          done_q <= 1'b1;
        end
      end else if (busy_q) begin
        beat_q <= beat_q + 1'b1;
        if (beat_q == slot_idx_t'(ElemsPerLane - 1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && pe_req_i.op == OP_VCPOP) begin
      cnt_q <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + beat_pop;
    end
  end

  assign cpop_result_o = cnt_q;
  assign done_o        = done_q;

endmodule : mask_unit

`default_nettype wire

/* rtl/spill_register.sv */
//////////////////////////////////////////////////////////////////////
// One-entry valid/ready buffer
// Registers any payload type and holds it until the consumer takes it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spill_register #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     full_q;
  payload_t data_q;

  assign ready_o = ~full_q;
  assign valid_o = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      full_q <= 1'b1;
    end else if (valid_o && ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

endmodule : spill_register

`default_nettype wire

/* rtl/vector_lane.sv */
//////////////////////////////////////////////////////////////////////
// Vector lane
// Holds this lane's slice of the register file, runs the element
// arithmetic and feeds mask bits and element 0 to the shared units
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vector_lane #(
  parameter int unsigned LaneId = 0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  ara_pkg::ara_req_t pe_req_i,
  input  logic              pe_req_valid_i,
  output logic              pe_req_ready_o,
  output logic              done_o,
  output logic              mask_bit_o,
  output logic              mask_bit_valid_o,
  output ara_pkg::elen_t    scalar_elem_o
);

  import ara_pkg::*;

  // Element e of a register sits here when e modulo NrLanes equals LaneId
  elen_t     vrf_q [NrVRegs][ElemsPerLane];

  ara_req_t  req_q;
  logic      busy_q;
  slot_idx_t slot_q;
  logic      last_slot;
  logic      wr_en;
  elen_t     wr_data;
  elen_t     op_a;
  elen_t     op_b;

  assign pe_req_ready_o = ~busy_q;
  assign last_slot      = (slot_q == slot_idx_t'(ElemsPerLane - 1));
  assign done_o         = busy_q & last_slot;

  // vd = vs2 op vs1
  assign op_a = vrf_q[req_q.vs2][slot_q];
  assign op_b = vrf_q[req_q.vs1][slot_q];

  ///////////////////////////////////////////////////////////////////
  // Slot sequencing
  ///////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      slot_q <= '0;
    end else if (pe_req_valid_i && pe_req_ready_o) begin
      busy_q <= 1'b1;
      slot_q <= '0;
    end else if (busy_q) begin
      slot_q <= slot_q + 1'b1;
      if (last_slot) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i && pe_req_ready_o) begin
      req_q <= pe_req_i;
    end
  end

  ///////////////////////////////////////////////////////////////////
  // Element arithmetic and write back
  ///////////////////////////////////////////////////////////////////

  always_comb begin
    wr_en   = busy_q;
    wr_data = '0;
    case (req_q.op)
      OP_VMV_VX: wr_data = req_q.scalar;
      // Global element index of this slot
      OP_VID:    wr_data = elen_t'(slot_q) * elen_t'(NrLanes) + elen_t'(LaneId);
      OP_VADD:   wr_data = op_a + op_b;
      OP_VSUB:   wr_data = op_a - op_b;
      OP_VAND:   wr_data = op_a & op_b;
      OP_VXOR:   wr_data = op_a ^ op_b;
      default:   wr_en   = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < NrVRegs; r++) begin
        for (int s = 0; s < ElemsPerLane; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else if (wr_en) begin
      vrf_q[req_q.vd][slot_q] <= wr_data;
    end
  end

  // Operands for the mask unit and the scalar move
  assign mask_bit_o       = op_a[0];
  assign mask_bit_valid_o = busy_q & (req_q.op == OP_VCPOP);
  assign scalar_elem_o    = vrf_q[req_q.vs2][0];

endmodule : vector_lane

`default_nettype wire

/* src.f */
rtl/ara_pkg.sv
rtl/spill_register.sv
rtl/ara_dispatcher.sv
rtl/ara_sequencer.sv
rtl/vector_lane.sv
rtl/mask_unit.sv
rtl/ara_top.sv
verification/ara_properties.sv
verification/ara_tb.sv

/* verification/ara_properties.sv */
//////////////////////////////////////////////////////////////////////
// Host channel properties
// Concurrent checks on the request and response handshakes of ara_top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ara_properties (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               acc_req_ready_o,
  input ara_pkg::acc_resp_t acc_resp_o,
  input logic               acc_resp_valid_o,
  input logic               acc_resp_ready_i
);

  // Response channel comes out of reset empty
  resp_idle_after_reset: assert property (
    @(posedge clk_i) !rst_n_i |=> !acc_resp_valid_o
  ) else $error("response valid high in the cycle after reset");

  // Stalled response holds valid and payload
  resp_stable_on_stall: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o)
  ) else $error("response dropped or changed while stalled");

  // Single instruction in flight
  no_accept_while_resp: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o |-> !acc_req_ready_o
  ) else $error("request ready high while a response waits");

endmodule : ara_properties

`default_nettype wire

/* verification/ara_tb.sv */
//////////////////////////////////////////////////////////////////////
// Vector accelerator testbench
// Random instruction stream against a register file model, with
// response stall checks on the host channel
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ara_tb;

  import ara_pkg::*;

  localparam int unsigned Seed          = 32'he23f;
  localparam int          TimeoutCycles = 100;

  logic      clk;
  logic      rst_n;
  acc_req_t  acc_req;
  logic      acc_req_valid;
  logic      acc_req_ready;
  acc_resp_t acc_resp;
  logic      acc_resp_valid;
  logic      acc_resp_ready;

  // Full registers, element e at index e
  elen_t model_vrf [NrVRegs][VLenElems];
  int    mismatches;
  int    failures;

  ara_top ara_top_i (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .acc_req_i       (acc_req),
    .acc_req_valid_i (acc_req_valid),
    .acc_req_ready_o (acc_req_ready),
    .acc_resp_o      (acc_resp),
    .acc_resp_valid_o(acc_resp_valid),
    .acc_resp_ready_i(acc_resp_ready)
  );

  bind ara_top ara_properties i_props (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .acc_req_ready_o (acc_req_ready_o),
    .acc_resp_o      (acc_resp_o),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i)
  );

  always #20 clk = ~clk;

  ///////////////////////////////////////////////////////////////////
  // Reporting
  ///////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatches++;
    $display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
  endtask

  task automatic finish_run();
    $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    failures++;
    $display("ERROR at %0t ns: timed out, %s", $time, what);
    finish_run();
  endtask

  ///////////////////////////////////////////////////////////////////
  // Register file model
  ///////////////////////////////////////////////////////////////////

  task automatic model_step(input logic [3:0] op, input vreg_idx_t vd, input vreg_idx_t vs1,
                            input vreg_idx_t vs2, input elen_t scalar,
                            output elen_t exp_result, output logic exp_error);
    int count;
    exp_result = '0;
    exp_error  = 1'b0;
    count      = 0;
    for (int e = 0; e < VLenElems; e++) begin
      // Destination is vs2 combined with vs1
      case (op)
        OP_VMV_VX: model_vrf[vd][e] = scalar;
        OP_VID:    model_vrf[vd][e] = elen_t'(e);
        OP_VADD:   model_vrf[vd][e] = model_vrf[vs2][e] + model_vrf[vs1][e];
        OP_VSUB:   model_vrf[vd][e] = model_vrf[vs2][e] - model_vrf[vs1][e];
        OP_VAND:   model_vrf[vd][e] = model_vrf[vs2][e] & model_vrf[vs1][e];
        OP_VXOR:   model_vrf[vd][e] = model_vrf[vs2][e] ^ model_vrf[vs1][e];
        OP_VCPOP:  count += model_vrf[vs2][e][0];
        OP_VMV_XS: exp_result = model_vrf[vs2][0];
        default:   exp_error = 1'b1;
      endcase
    end
    if (op == OP_VCPOP) begin
      exp_result = elen_t'(count);
    end
  endtask

  ///////////////////////////////////////////////////////////////////
  // Host driver, called and returning on a falling edge
  ///////////////////////////////////////////////////////////////////

  task automatic run_instr(input logic [3:0] op, input vreg_idx_t vd, input vreg_idx_t vs1,
                           input vreg_idx_t vs2, input elen_t scalar, input int stall);
    acc_resp_t got;
    acc_resp_t held;
    elen_t     exp_result;
    logic      exp_error;
    int        waited;
    model_step(op, vd, vs1, vs2, scalar, exp_result, exp_error);
    acc_req        = '{op: op, vd: vd, vs1: vs1, vs2: vs2, scalar: scalar};
    acc_req_valid  = 1'b1;
    acc_resp_ready = (stall == 0);
    waited = 0;
    while (!acc_req_ready) begin
      @(negedge clk);
      waited++;
      if (waited > TimeoutCycles) abort_on_timeout("request was never accepted");
    end
    @(negedge clk);
    acc_req_valid = 1'b0;
    waited = 0;
    while (!acc_resp_valid) begin
      @(negedge clk);
      waited++;
      if (waited > TimeoutCycles) abort_on_timeout("no response arrived");
    end
    held = acc_resp;
    for (int i = 0; i < stall; i++) begin
      if (acc_req_ready !== 1'b0) report_mismatch("acc_req_ready_o", 0, acc_req_ready);
      @(negedge clk);
      if (acc_resp_valid !== 1'b1) report_mismatch("acc_resp_valid_o", 1, acc_resp_valid);
      if (acc_resp !== held) report_mismatch("acc_resp_o", held, acc_resp);
    end
    acc_resp_ready = 1'b1;
    got = acc_resp;
    @(negedge clk);
    if (got.result !== exp_result) report_mismatch("acc_resp_o.result", exp_result, got.result);
    if (got.error !== exp_error) report_mismatch("acc_resp_o.error", exp_error, got.error);
  endtask

  function automatic vreg_idx_t rand_reg();
    return vreg_idx_t'($urandom_range(NrVRegs - 1));
  endfunction

  function automatic elen_t rand_elem();
    return elen_t'($urandom);
  endfunction

  function automatic logic [3:0] pick_write_op();
    case ($urandom_range(5))
      0:       return OP_VID;
      1:       return OP_VMV_VX;
      2:       return OP_VADD;
      3:       return OP_VSUB;
      4:       return OP_VAND;
      default: return OP_VXOR;
    endcase
  endfunction

  ///////////////////////////////////////////////////////////////////
  // Test sequence
  ///////////////////////////////////////////////////////////////////

  initial begin
    vreg_idx_t  vd;
    elen_t      value;
    int         stall;
    void'($urandom(Seed));
    clk            = 1'b0;
    rst_n          = 1'b0;
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    acc_resp_ready = 1'b1;
    mismatches     = 0;
    failures       = 0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < VLenElems; e++) begin
        model_vrf[r][e] = '0;
      end
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Reads straight after reset
    for (int i = 0; i < 4; i++) begin
      run_instr(OP_VMV_XS, rand_reg(), rand_reg(), rand_reg(), rand_elem(), 0);
      run_instr(OP_VCPOP, rand_reg(), rand_reg(), rand_reg(), rand_elem(), 0);
    end

    // Broadcast and read back
    for (int i = 0; i < 4; i++) begin
      vd    = rand_reg();
      value = rand_elem();
      run_instr(OP_VMV_VX, vd, rand_reg(), rand_reg(), value, 0);
      run_instr(OP_VMV_XS, rand_reg(), rand_reg(), vd, rand_elem(), 0);
    end

    // Random arithmetic stream
    for (int i = 0; i < 60; i++) begin
      vd = rand_reg();
      run_instr(pick_write_op(), vd, rand_reg(), rand_reg(), rand_elem(), 0);
      run_instr(OP_VMV_XS, rand_reg(), rand_reg(), vd, rand_elem(), 0);
      run_instr(OP_VCPOP, rand_reg(), rand_reg(), vd, rand_elem(), 0);
    end

    // Undefined op codes leave the registers alone
    for (int i = 0; i < 10; i++) begin
      vd = rand_reg();
      run_instr(4'($urandom_range(15, 8)), vd, rand_reg(), rand_reg(), rand_elem(), 0);
      run_instr(OP_VMV_XS, rand_reg(), rand_reg(), vd, rand_elem(), 0);
      run_instr(OP_VCPOP, rand_reg(), rand_reg(), vd, rand_elem(), 0);
    end

    // Response back-pressure
    for (int i = 0; i < 8; i++) begin
      vd    = rand_reg();
      stall = $urandom_range(6, 1);
      run_instr(pick_write_op(), vd, rand_reg(), rand_reg(), rand_elem(), stall);
      run_instr(OP_VMV_XS, rand_reg(), rand_reg(), vd, rand_elem(), stall);
    end

    finish_run();
  end

endmodule : ara_tb

`default_nettype wire
